//--- rtl/pin_bus_pkg.sv
/* Shared widths, frame constants and controller states for the byte-serial memory bridge.
   Imported by the bridge RTL and referenced by the testbench and checker. */

package pin_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BYTE_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;      // Host byte address
  typedef logic [DATA_W-1:0] word_t;      // Write data and read data
  typedef logic [BYTE_W-1:0] pin_byte_t;  // One beat on an 8-bit pin group
  typedef logic [1:0]        beat_idx_t;  // Beat number inside a 4-beat phase

  // Frame format
  localparam int unsigned OUT_BEATS = 4;  // Marker plus three page address bytes
  localparam int unsigned IN_BEATS  = 4;  // Read word, low byte first

  localparam pin_byte_t MARK_READ  = 8'hFF;
  localparam pin_byte_t MARK_WRITE = 8'hFE;
  localparam pin_byte_t IDLE_BYTE  = 8'h00;  // uo_out between frames

  typedef enum logic [1:0] {
    IDLE,       // Waiting for a host request
    OUT_PHASE,  // Marker and address on uo_out
    IN_PHASE,   // Turnaround, then read bytes on uio_in
    ACK_WAIT    // Holding ack until req falls
  } ctrl_state_t;

endpackage

//--- rtl/pin_beat_if.sv
/* Beat control from the frame controller to the transmit shifter and receive assembler.
   The controller drives every signal; the datapath modules only listen. */

`timescale 1ns/100ps

interface pin_beat_if;
  import pin_bus_pkg::*;

  logic      load;      // One-cycle pulse when a request is accepted
  logic      is_write;  // Frame direction, stable for the whole frame
  logic      out_en;    // Output beats in progress
  logic      in_en;     // Input beats in progress
  beat_idx_t beat_idx;  // Beat within the current phase

  modport ctrl (
    output load,
    output is_write,
    output out_en,
    output in_en,
    output beat_idx
  );

  modport tx (
    input load,
    input is_write,
    input out_en,
    input beat_idx
  );

  modport rx (
    input load,
    input in_en,
    input beat_idx
  );

endinterface

//--- rtl/pin_bus_ctrl.sv
/* Frame controller of the memory bridge. Accepts a four-phase req/ack request,
   sequences the output beats, the read turnaround and input beats, then holds ack. */

`timescale 1ns/100ps

module pin_bus_ctrl (
  input  logic     clk,
  input  logic     reset,
  input  logic     req,
  input  logic     rw,
  output logic     ack,
  pin_beat_if.ctrl beat
);
  import pin_bus_pkg::*;

  ctrl_state_t state;
  beat_idx_t   cnt;         // Beat counter shared by both phases
  logic        is_write_q;
  logic        turn;        // Bus turnaround cycle ahead of the input beats
  logic        req_low;     // req sampled low while ack is high
  logic        last_out;
  logic        last_in;

  assign last_out = (cnt == beat_idx_t'(OUT_BEATS - 1));
  assign last_in  = (cnt == beat_idx_t'(IN_BEATS - 1));

  // Beat control seen by the datapath
  assign beat.load     = (state == IDLE) && req;  // Datapath latches the host fields here
  assign beat.is_write = is_write_q;
  assign beat.out_en   = (state == OUT_PHASE);
  assign beat.in_en    = (state == IN_PHASE) && !turn;
  assign beat.beat_idx = cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      cnt        <= '0;
      is_write_q <= 1'b0;
      turn       <= 1'b0;
      req_low    <= 1'b0;
      ack        <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state      <= OUT_PHASE;
            cnt        <= '0;
            is_write_q <= rw;  // Direction fixed for the frame
          end
        end

        OUT_PHASE: begin
          cnt <= cnt + 1'b1;  // Wraps to zero after the last beat
          if (last_out) begin
            if (is_write_q) begin
              state <= ACK_WAIT;
            end else begin
              state <= IN_PHASE;
              turn  <= 1'b1;
            end
          end
        end

        IN_PHASE: begin
          if (turn) begin
            turn <= 1'b0;  // uio released for one cycle before sampling
          end else begin
            cnt <= cnt + 1'b1;
            if (last_in) begin
              state <= ACK_WAIT;
            end
          end
        end

        ACK_WAIT: begin
          // ack falls one cycle after req is seen low
          if (!ack) begin
            ack <= 1'b1;
          end else if (req_low) begin
            ack     <= 1'b0;
            req_low <= 1'b0;
            state   <= IDLE;
          end else if (!req) begin
            req_low <= 1'b1;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/pin_tx_shifter.sv
/* Transmit side of the bridge. Latches a request on load and registers the marker,
   page address bytes, write data bytes and output enable for each output beat. */

`timescale 1ns/100ps

module pin_tx_shifter (
  input  logic                  clk,
  input  logic                  reset,
  input  pin_bus_pkg::addr_t    addr,
  input  pin_bus_pkg::word_t    wdata,
  pin_beat_if.tx                beat,
  output pin_bus_pkg::pin_byte_t uo_out,
  output pin_bus_pkg::pin_byte_t uio_out,
  output pin_bus_pkg::pin_byte_t uio_oe
);
  import pin_bus_pkg::*;

  logic [23:0] page_q;    // Address bits 31:8, the low byte never leaves the chip
  word_t       wdata_q;
  pin_byte_t   out_byte;

  // Request fields, held for the whole frame
  always_ff @(posedge clk) begin
    if (beat.load) begin
      page_q  <= addr[31:8];
      wdata_q <= wdata;
    end
  end

  always_comb begin
    case (beat.beat_idx)
      beat_idx_t'(0): out_byte = beat.is_write ? MARK_WRITE : MARK_READ;
      beat_idx_t'(1): out_byte = page_q[7:0];
      beat_idx_t'(2): out_byte = page_q[15:8];
      default:        out_byte = page_q[23:16];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out  <= IDLE_BYTE;
      uio_out <= '0;
      uio_oe  <= '0;
    end else if (beat.out_en) begin
      uo_out  <= out_byte;
      uio_out <= wdata_q[8*beat.beat_idx +: 8];  // Low byte first
      uio_oe  <= beat.is_write ? '1 : '0;        // Reads leave uio to the device
    end else begin
      uo_out <= IDLE_BYTE;
      uio_oe <= '0;  // uio_out keeps its last byte
    end
  end

endmodule

//--- rtl/pin_rx_assembler.sv
/* Receive side of the bridge. Builds the 32-bit read word from the input beats
   of a read frame; the word is cleared at the start of every frame. */

`timescale 1ns/100ps

module pin_rx_assembler (
  input  logic                   clk,
  input  logic                   reset,
  input  pin_bus_pkg::pin_byte_t uio_in,
  pin_beat_if.rx                 beat,
  output pin_bus_pkg::word_t     rdata
);

  // rdata is the assembled word itself
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (beat.load) begin
      rdata <= '0;  // A write frame leaves it at zero
    end else if (beat.in_en) begin
      rdata[8*beat.beat_idx +: 8] <= uio_in;  // Byte lane picked by beat number
    end
  end

endmodule

//--- rtl/pin_bus_bridge.sv
/* Top level of the byte-serial memory bridge. Carries a 32-bit host request
   over the 8-bit uo/uio pins using a four-phase req/ack handshake. */

`timescale 1ns/100ps

module pin_bus_bridge (
  input  logic        clk,
  input  logic        reset,
  // Host port
  input  logic        req,
  input  logic        rw,       // High for write
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic        ack,
  output logic [31:0] rdata,
  // Pins
  output logic [7:0]  uo_out,
  output logic [7:0]  uio_out,
  output logic [7:0]  uio_oe,
  input  logic [7:0]  uio_in
);

  pin_beat_if beat ();

  pin_bus_ctrl u_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rw    (rw),
    .ack   (ack),
    .beat  (beat.ctrl)
  );

  pin_tx_shifter u_tx (
    .clk     (clk),
    .reset   (reset),
    .addr    (addr),
    .wdata   (wdata),
    .beat    (beat.tx),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  pin_rx_assembler u_rx (
    .clk    (clk),
    .reset  (reset),
    .uio_in (uio_in),
    .beat   (beat.rx),
    .rdata  (rdata)
  );

endmodule

//--- dv/pin_bus_bridge_chk.sv
/* Concurrent assertions on the host handshake, pin timing and read data of the bridge.
   Bound into pin_bus_bridge; the testbench reads fail_count for its summary. */

`timescale 1ns/100ps

module pin_bus_bridge_chk (
  input logic        clk,
  input logic        reset,
  input logic        req,
  input logic        rw,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input logic        ack,
  input logic [31:0] rdata,
  input logic [7:0]  uo_out,
  input logic [7:0]  uio_out,
  input logic [7:0]  uio_oe,
  input logic [7:0]  uio_in
);
  import pin_bus_pkg::*;

  logic        busy;       // Frame running or ack still high
  logic        drop_seen;  // req seen low while ack is high
  logic        started;    // At least one request since reset
  logic        start;      // Edge 0 of a frame
  int unsigned fail_count = 0;

  assign start = !busy && req;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      drop_seen <= 1'b0;
      started   <= 1'b0;
    end else begin
      if (start) begin
        busy    <= 1'b1;
        started <= 1'b1;
      end
      if (drop_seen) begin
        busy      <= 1'b0;  // ack falls on this edge
        drop_seen <= 1'b0;
      end else if (busy && ack && !req) begin
        drop_seen <= 1'b1;
      end
    end
  end

  property p_write_frame;
    @(posedge clk) disable iff (reset)
      start && rw |-> ##1 (!ack && uo_out == IDLE_BYTE)
        ##1 (uo_out == MARK_WRITE && uio_out == wdata[7:0] && uio_oe == 8'hFF && !ack)
        ##1 (uo_out == addr[15:8] && uio_out == wdata[15:8] && uio_oe == 8'hFF && !ack)
        ##1 (uo_out == addr[23:16] && uio_out == wdata[23:16] && uio_oe == 8'hFF && !ack)
        ##1 (uo_out == addr[31:24] && uio_out == wdata[31:24] && uio_oe == 8'hFF && !ack)
        ##1 (uo_out == IDLE_BYTE && uio_oe == 8'h00 && ack);
  endproperty

  // Input beats sampled at edges 6 to 9, ack seen at edge 11
  property p_read_frame;
    @(posedge clk) disable iff (reset)
      start && !rw |-> ##2 (uo_out == MARK_READ && uio_oe == 8'h00 && !ack)
        ##1 (uo_out == addr[15:8] && uio_oe == 8'h00 && !ack)
        ##1 (uo_out == addr[23:16] && uio_oe == 8'h00 && !ack)
        ##1 (uo_out == addr[31:24] && uio_oe == 8'h00 && !ack)
        ##1 (uo_out == IDLE_BYTE && uio_oe == 8'h00 && !ack) [*5]
        ##1 (ack && rdata == {$past(uio_in, 2), $past(uio_in, 3),
                              $past(uio_in, 4), $past(uio_in, 5)});
  endproperty

  a_write_frame: assert property (p_write_frame)
    else begin
      fail_count++;
      $error("Write frame pins or ack timing wrong");
    end

  a_read_frame: assert property (p_read_frame)
    else begin
      fail_count++;
      $error("Read frame pins, ack timing or rdata wrong");
    end

  a_ack_hold: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
    else begin
      fail_count++;
      $error("ack dropped while req still high");
    end

  a_rdata_stable: assert property (
    @(posedge clk) disable iff (reset) ack && $past(ack) |-> $stable(rdata))
    else begin
      fail_count++;
      $error("rdata changed while ack high");
    end

  a_ack_release: assert property (
    @(posedge clk) disable iff (reset) ack && !req && $past(req) |=> ack ##1 !ack)
    else begin
      fail_count++;
      $error("ack did not fall one cycle after req was sampled low");
    end

  a_quiet_pins: assert property (
    @(posedge clk) disable iff (reset)
      (!busy || ack) |-> uo_out == IDLE_BYTE && uio_oe == 8'h00 && (busy || !ack))
    else begin
      fail_count++;
      $error("Pins active or ack high outside a frame");
    end

  a_reset_values: assert property (
    @(posedge clk) disable iff (reset) !started |-> rdata == '0 && uio_out == 8'h00)
    else begin
      fail_count++;
      $error("rdata or uio_out not at reset value before the first request");
    end

endmodule

bind pin_bus_bridge pin_bus_bridge_chk u_chk (.*);

//--- dv/tb_pin_bus_bridge.sv
/* Testbench for the byte-serial memory bridge. Drives host frames, models the pin-side
   page memory, checks data words and prints one line per test plus a summary. */

`timescale 1ns/100ps

module tb_pin_bus_bridge;
  import pin_bus_pkg::*;

  localparam int WAIT_LIMIT = 40;  // Cycles allowed for each handshake wait

  logic      clk;
  logic      reset;
  logic      req;
  logic      rw;
  addr_t     addr;
  word_t     wdata;
  logic      ack;
  word_t     rdata;
  pin_byte_t uo_out;
  pin_byte_t uio_out;
  pin_byte_t uio_oe;
  pin_byte_t uio_in;

  int    seed       = 87265;
  int    err_count  = 0;
  int    test_count = 0;
  logic  timed_out  = 1'b0;
  word_t page_mem [logic [23:0]];  // Pin-side memory, random on first touch
  word_t written  [logic [23:0]];  // Last host write per page

  // Pin model state
  logic        in_frame;
  logic        frame_wr;
  int          beat_no;
  int          rd_beat;   // Next read byte to drive, -1 when idle
  logic [23:0] page;
  word_t       wr_word;
  word_t       model_word;

  pin_bus_bridge u_pin_bus_bridge (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .rw      (rw),
    .addr    (addr),
    .wdata   (wdata),
    .ack     (ack),
    .rdata   (rdata),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

  always #4 clk = ~clk;

  function automatic int total_errors();
    return err_count + int'(u_pin_bus_bridge.u_chk.fail_count);
  endfunction

  function automatic word_t fetch_page_word(input logic [23:0] pg);
    if (!page_mem.exists(pg)) begin
      page_mem[pg] = $random(seed);
    end
    return page_mem[pg];
  endfunction

  task automatic compare_word(input string name, input word_t expect_v, input word_t actual_v);
    if (actual_v !== expect_v) begin
      err_count++;
      $display("[FAIL] %0t ns %s expected 0x%h got 0x%h", $time, name, expect_v, actual_v);
    end
  endtask

  // Device side of the pins, one step per clock just after the edge
  always @(posedge clk) begin
    #1;
    if (reset) begin
      in_frame = 1'b0;
      rd_beat  = -1;
      uio_in   = 8'h00;
    end else begin
      if (rd_beat >= 0 && rd_beat < int'(IN_BEATS)) begin
        model_word = fetch_page_word(page);
        uio_in     = model_word[8*rd_beat +: 8];  // Low byte first
        rd_beat++;
      end else if (rd_beat >= int'(IN_BEATS)) begin
        uio_in  = 8'h00;
        rd_beat = -1;
      end
      if (!in_frame && (uo_out == MARK_WRITE || uo_out == MARK_READ)) begin
        in_frame     = 1'b1;
        frame_wr     = (uo_out == MARK_WRITE);
        beat_no      = 1;
        wr_word[7:0] = uio_out;
      end else if (in_frame) begin
        page[8*(beat_no-1) +: 8] = uo_out;
        wr_word[8*beat_no +: 8]  = uio_out;
        if (beat_no == int'(OUT_BEATS) - 1) begin
          in_frame = 1'b0;
          if (frame_wr) begin
            page_mem[page] = wr_word;
          end else begin
            rd_beat = 0;  // First byte goes out after the turnaround cycle
          end
        end
        beat_no++;
      end
    end
  end

  // One four-phase host transfer, req held hold extra cycles after ack
  task automatic run_frame(input string name, input logic is_wr, input addr_t a,
                           input word_t d, input int hold);
    int          n;
    logic [23:0] pg;
    word_t       expect_w;
    if (timed_out) return;
    pg = a[31:8];
    @(posedge clk);
    #1;
    rw    = is_wr;
    addr  = a;
    wdata = d;
    req   = 1'b1;
    n = 0;
    while (ack !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ack !== 1'b1) begin
      $display("%0t ns: ack did not rise within %0d cycles in %s", $time, WAIT_LIMIT, name);
      err_count++;
      timed_out = 1'b1;
      req = 1'b0;
      return;
    end
    if (is_wr) begin
      written[pg] = d;
      compare_word("page_mem", d, fetch_page_word(pg));
      compare_word("rdata", '0, rdata);
    end else begin
      expect_w = written.exists(pg) ? written[pg] : fetch_page_word(pg);
      compare_word("rdata", expect_w, rdata);
    end
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    n = 0;
    while (ack !== 1'b0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ack !== 1'b0) begin
      $display("%0t ns: ack did not fall within %0d cycles in %s", $time, WAIT_LIMIT, name);
      err_count++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (total_errors() == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial begin
    int          errs;
    int          r;
    int          r2;
    addr_t       a;
    logic [23:0] last_page;
    logic        have_page;
    clk    = 1'b0;
    reset  = 1'b1;
    req    = 1'b0;
    rw     = 1'b0;
    addr   = '0;
    wdata  = '0;
    uio_in = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    errs = total_errors();
    repeat (4) @(posedge clk);
    #1;
    compare_word("ack", '0, ack);
    compare_word("uio_oe", '0, uio_oe);
    compare_word("uo_out", IDLE_BYTE, uo_out);
    compare_word("rdata", '0, rdata);
    report_test("reset", errs);

    errs = total_errors();
    run_frame("write", 1'b1, 32'hA5C3_3C5A, 32'h1234_5678, 0);
    report_test("write", errs);

    errs = total_errors();
    run_frame("read", 1'b0, 32'h0102_0304, '0, 0);
    run_frame("read", 1'b0, 32'hA5C3_3C00, '0, 0);  // Same page as the write
    report_test("read", errs);

    errs = total_errors();
    run_frame("handshake", 1'b0, 32'h0102_03F0, '0, 6);
    run_frame("handshake", 1'b1, 32'h7E00_1188, 32'hCAFE_F00D, 5);
    report_test("handshake", errs);

    errs = total_errors();
    have_page = 1'b0;
    last_page = '0;
    for (int i = 0; i < 20; i++) begin
      r  = $random(seed);
      r2 = $random(seed);
      a  = (have_page && r[1]) ? {last_page, r2[7:0]} : addr_t'(r2);
      if (r[0]) begin
        last_page = a[31:8];
        have_page = 1'b1;
      end
      run_frame("random", r[0], a, $random(seed), r[3:2]);
    end
    report_test("random", errs);

    $display("%0d tests, %0d errors", test_count, total_errors());
    if (total_errors() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sources.f
rtl/pin_bus_pkg.sv
rtl/pin_beat_if.sv
rtl/pin_bus_ctrl.sv
rtl/pin_tx_shifter.sv
rtl/pin_rx_assembler.sv
rtl/pin_bus_bridge.sv
dv/pin_bus_bridge_chk.sv
dv/tb_pin_bus_bridge.sv

//--- Bender.yml
package:
  name: pin_bus_bridge

sources:
  # Design
  - rtl/pin_bus_pkg.sv
  - rtl/pin_beat_if.sv
  - rtl/pin_bus_ctrl.sv
  - rtl/pin_tx_shifter.sv
  - rtl/pin_rx_assembler.sv
  - rtl/pin_bus_bridge.sv
  # Verification
  - target: test
    files:
      - dv/pin_bus_bridge_chk.sv
      - dv/tb_pin_bus_bridge.sv
